// File: filelist.f
ctx_pkg.sv
ctx_word_if.sv
ctx_event_decode.sv
ctx_short_fifo.sv
ctx_pkt_builder.sv
ctx_report_top.sv
ctx_report_checker.sv
ctx_report_monitor.sv
ctx_report_tb.sv

// File: Makefile
VERILATOR       ?= verilator
TOP             ?= ctx_report_tb
FILELIST        ?= filelist.f
BUILD_DIR       ?= obj_dir
PROT_ENG_FLAGS  ?= 1
FIFO_DEPTH_LOG2 ?= 2
VFLAGS          ?= --binary --timing --assert
SIM_ARGS        ?= +verilator+error+limit+1000

PARAMS = -GPROT_ENG_FLAGS=$(PROT_ENG_FLAGS) -GFIFO_DEPTH_LOG2=$(FIFO_DEPTH_LOG2)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) $(PARAMS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert $(PARAMS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: ctx_report_tb.sv
`default_nettype none

module ctx_report_tb;

   parameter bit PROT_ENG_FLAGS  = 1'b1;
   parameter int FIFO_DEPTH_LOG2 = 2;

   localparam int          NUM_EVT        = 12;
   localparam int          NUM_PASS       = 2;
   localparam int          TIMEOUT_CYCLES = NUM_EVT * NUM_PASS * 40 + 200;
   localparam int          LONG_STALL     = 50;
   localparam int          SEED           = 41675;
   localparam logic [31:0] STREAM_ID      = 32'h5a5a_0c17;

   logic        clk;
   logic        reset;
   logic        evt_valid_i;
   logic [3:0]  evt_code_i;
   logic [63:0] vita_time_i;
   logic [31:0] seqnum0_i;
   logic [31:0] seqnum1_i;
   logic [31:0] stream_id_i;
   logic        out_ready_i;
   logic        evt_ready_o;
   logic        out_valid_o;
   logic [31:0] out_data_o;
   logic        out_sop_o;
   logic        out_eop_o;

   logic [3:0]  code_tbl [NUM_EVT];
   logic [63:0] time_tbl [NUM_EVT];
   logic [31:0] sq0_tbl [NUM_EVT];
   logic [31:0] sq1_tbl [NUM_EVT];
   int          gap_tbl [NUM_EVT];

   int   cycle_cnt = 0;
   int   sent_cnt = 0;
   int   stall_left = LONG_STALL;
   int   data_errs;
   int   ready_errs;
   int   extra_words;
   int   pending_words;
   logic evt_stalled;
   logic mon_done;

   ctx_report_top #(.PROT_ENG_FLAGS(PROT_ENG_FLAGS), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) UUT
   (
      .clk         (clk),
      .reset       (reset),
      .evt_valid_i (evt_valid_i),
      .evt_code_i  (evt_code_i),
      .vita_time_i (vita_time_i),
      .seqnum0_i   (seqnum0_i),
      .seqnum1_i   (seqnum1_i),
      .stream_id_i (stream_id_i),
      .evt_ready_o (evt_ready_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_sop_o   (out_sop_o),
      .out_eop_o   (out_eop_o),
      .out_ready_i (out_ready_i)
   );

   ctx_report_monitor #(
      .PROT_ENG_FLAGS (PROT_ENG_FLAGS),
      .NUM_EVT        (NUM_EVT),
      .NUM_PASS       (NUM_PASS),
      .STREAM_ID      (STREAM_ID)
   ) u_monitor
   (
      .clk           (clk),
      .reset         (reset),
      .evt_ready_i   (evt_ready_o),
      .out_valid_i   (out_valid_o),
      .out_ready_i   (out_ready_i),
      .out_data_i    (out_data_o),
      .out_sop_i     (out_sop_o),
      .out_eop_i     (out_eop_o),
      .code_tbl_i    (code_tbl),
      .time_tbl_i    (time_tbl),
      .sq0_tbl_i     (sq0_tbl),
      .sq1_tbl_i     (sq1_tbl),
      .data_errs_o   (data_errs),
      .ready_errs_o  (ready_errs),
      .extra_o       (extra_words),
      .pending_o     (pending_words),
      .evt_stalled_o (evt_stalled),
      .done_o        (mon_done)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   task automatic set_entry(input int i, input logic [3:0] code, input logic [63:0] t,
                            input logic [31:0] s0, input logic [31:0] s1, input int gap);
      code_tbl[i] = code;
      time_tbl[i] = t;
      sq0_tbl[i]  = s0;
      sq1_tbl[i]  = s1;
      gap_tbl[i]  = gap;
   endtask

   // an event is raised only while evt_ready_o is high, so it transfers on the next edge.
   task automatic send_event(input int idx);
      while (!evt_ready_o)
         @(negedge clk);
      evt_valid_i = 1'b1;
      evt_code_i  = code_tbl[idx];
      vita_time_i = time_tbl[idx];
      seqnum0_i   = sq0_tbl[idx];
      seqnum1_i   = sq1_tbl[idx];
      @(negedge clk);
      evt_valid_i = 1'b0;
      sent_cnt++;
      repeat (gap_tbl[idx])
         @(negedge clk);
   endtask

   task automatic print_counts();
      $display("errors: %0d data, %0d ready, %0d missing words, %0d extra words, %0d assertion",
               data_errs, ready_errs, pending_words, extra_words,
               UUT.u_checker.assert_fails);
   endtask

   task automatic end_run();
      int total;
      total = data_errs + ready_errs + pending_words + extra_words
              + UUT.u_checker.assert_fails;
      if (!evt_stalled)
      begin
         $display("evt_ready_o never dropped while the output was stalled");
         total++;
      end
      print_counts();
      if (total == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   // ##############################
   // stimulus
   // ##############################

   initial
   begin
      void'($urandom(SEED));
      reset       = 1'b1;
      evt_valid_i = 1'b0;
      evt_code_i  = 4'd0;
      vita_time_i = 64'd0;
      seqnum0_i   = 32'd0;
      seqnum1_i   = 32'd0;
      stream_id_i = STREAM_ID;
      set_entry(0,  4'd1, 64'h0000_0010_0000_0100, 32'd1,  32'd100, 2);
      set_entry(1,  4'd1, 64'h0000_0011_0000_0200, 32'd2,  32'd101, 0);
      set_entry(2,  4'd2, 64'h0000_0012_0abc_0300, 32'd3,  32'd102, 3);
      set_entry(3,  4'd6, 64'h0000_0013_0000_0400, 32'd4,  32'd103, 1);
      set_entry(4,  4'd0, 64'h0000_0014_0000_0500, 32'd5,  32'd104, 0);
      set_entry(5,  4'd3, 64'hdead_0015_0000_0600, 32'd6,  32'd105, 5);
      set_entry(6,  4'd1, 64'h0000_0016_ffff_0700, 32'd7,  32'd106, 0);
      set_entry(7,  4'd9, 64'h0000_0017_0000_0800, 32'd8,  32'd107, 1);
      set_entry(8,  4'd4, 64'h1234_0018_0000_0900, 32'd9,  32'd108, 0);
      set_entry(9,  4'd5, 64'h0000_0019_5555_0a00, 32'd10, 32'd109, 2);
      set_entry(10, 4'd6, 64'h0000_001a_0000_0b00, 32'd11, 32'd110, 0);
      set_entry(11, 4'hf, 64'hffff_001b_0000_0c00, 32'd12, 32'd111, 4);
      repeat (5) @(negedge clk);
      reset = 1'b0;
      for (int pass = 0; pass < NUM_PASS; pass++)
      begin
         for (int i = 0; i < NUM_EVT; i++)
         begin
            send_event(i);
         end
      end
      while (!mon_done)
         @(negedge clk);
      // a quiet window where any extra word would still show up.
      repeat (20) @(negedge clk);
      end_run();
   end

   // full speed for the first third, then random stalls with one long stall in pass two.
   initial
   begin
      out_ready_i = 1'b1;
      forever
      begin
         @(negedge clk);
         if (sent_cnt < NUM_EVT / 3)
            out_ready_i = 1'b1;
         else if (sent_cnt >= NUM_EVT && stall_left > 0)
         begin
            out_ready_i = 1'b0;
            stall_left--;
         end
         else
            out_ready_i = (($urandom % 4) != 0);
      end
   end

   initial
   begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("timeout, the run did not complete within %0d cycles", TIMEOUT_CYCLES);
      if (pending_words > 0)
         $display("%0d expected output words never arrived", pending_words);
      print_counts();
      $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: ctx_report_monitor.sv
`default_nettype none

module ctx_report_monitor
#(
   parameter bit          PROT_ENG_FLAGS = 1'b1,
   parameter int          NUM_EVT        = 12,
   parameter int          NUM_PASS       = 2,
   parameter logic [31:0] STREAM_ID      = 32'd0
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        evt_ready_i,
   input  logic        out_valid_i,
   input  logic        out_ready_i,
   input  logic [31:0] out_data_i,
   input  logic        out_sop_i,
   input  logic        out_eop_i,
   input  logic [3:0]  code_tbl_i [NUM_EVT],
   input  logic [63:0] time_tbl_i [NUM_EVT],
   input  logic [31:0] sq0_tbl_i [NUM_EVT],
   input  logic [31:0] sq1_tbl_i [NUM_EVT],
   output int          data_errs_o,
   output int          ready_errs_o,
   output int          extra_o,
   output int          pending_o,
   output logic        evt_stalled_o,
   output logic        done_o
);

   // each entry is {eop, sop, data}.
   logic [33:0] exp_q [$];
   logic [23:0] class_cnt [256];
   logic        built;

   function automatic logic [7:0] class_of(input logic [3:0] code);
      case (code)
         4'd1:    return ctx_pkg::MSG_OVERFLOW;
         4'd2:    return ctx_pkg::MSG_UNDERFLOW;
         4'd3:    return ctx_pkg::MSG_LATE_CMD;
         4'd4:    return ctx_pkg::MSG_SEQ_ERR;
         4'd5:    return ctx_pkg::MSG_BROKEN_CHAIN;
         4'd6:    return ctx_pkg::MSG_ACK;
         default: return ctx_pkg::MSG_UNKNOWN;
      endcase
   endfunction

   task automatic push_word(input logic eop, input logic sop, input logic [31:0] data);
      exp_q.push_back({eop, sop, data});
   endtask

   // ##############################
   // expected packet list
   // ##############################

   task automatic build_expected();
      logic [7:0] cls;
      logic [3:0] seq;
      logic       hdr_type;
      seq      = 4'd0;
      hdr_type = !PROT_ENG_FLAGS;
      for (int c = 0; c < 256; c++)
         class_cnt[c] = 24'd0;
      for (int pass = 0; pass < NUM_PASS; pass++)
      begin
         for (int i = 0; i < NUM_EVT; i++)
         begin
            if (code_tbl_i[i] != ctx_pkg::EVT_NONE)
            begin
               cls            = class_of(code_tbl_i[i]);
               class_cnt[cls] = class_cnt[cls] + 24'd1;
               if (PROT_ENG_FLAGS)
                  push_word(1'b0, 1'b1, ctx_pkg::CTX_PROT_WORD);
               push_word(1'b0, hdr_type,
                         {hdr_type, ctx_pkg::CTX_PKT_TYPE[10:0], seq, ctx_pkg::CTX_HDR_LEN});
               push_word(1'b0, 1'b0, STREAM_ID);
               push_word(1'b0, 1'b0, time_tbl_i[i][63:32]);
               push_word(1'b0, 1'b0, 32'd0);
               push_word(1'b0, 1'b0, time_tbl_i[i][31:0]);
               push_word(1'b0, 1'b0, {cls, class_cnt[cls]});
               push_word(1'b0, 1'b0, sq0_tbl_i[i]);
               push_word(1'b1, 1'b0, sq1_tbl_i[i]);
               seq = seq + 4'd1;
            end
         end
      end
   endtask

   task automatic check_word();
      logic [33:0] exp;
      if (exp_q.size() == 0)
      begin
         extra_o++;
         $display("extra output word %h at time %0t after the last expected packet",
                  out_data_i, $time);
      end
      else
      begin
         exp = exp_q.pop_front();
         if (out_data_i !== exp[31:0])
         begin
            data_errs_o++;
            $display("ERR %0t out_data_o expected %h actual %h", $time, exp[31:0], out_data_i);
         end
         if (out_sop_i !== exp[32])
         begin
            data_errs_o++;
            $display("ERR %0t out_sop_o expected %b actual %b", $time, exp[32], out_sop_i);
         end
         if (out_eop_i !== exp[33])
         begin
            data_errs_o++;
            $display("ERR %0t out_eop_o expected %b actual %b", $time, exp[33], out_eop_i);
         end
      end
      pending_o = exp_q.size();
      done_o    = (pending_o == 0);
   endtask

   initial
   begin
      built         = 1'b0;
      done_o        = 1'b0;
      evt_stalled_o = 1'b0;
      data_errs_o   = 0;
      ready_errs_o  = 0;
      extra_o       = 0;
      pending_o     = 0;
      @(negedge reset);
      // the decode slot is empty after reset, so an event is taken at once.
      if (evt_ready_i !== 1'b1)
      begin
         ready_errs_o++;
         $display("ERR %0t evt_ready_o expected 1 actual %b", $time, evt_ready_i);
      end
      build_expected();
      pending_o = exp_q.size();
      done_o    = (pending_o == 0);
      built     = 1'b1;
   end

   always @(posedge clk)
   begin
      if (!reset && built && out_valid_i && out_ready_i)
         check_word();
      // back-pressure from the output reaches the event input.
      if (!reset && evt_ready_i === 1'b0)
         evt_stalled_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: ctx_report_checker.sv
`default_nettype none

module ctx_report_checker
(
   input logic        clk,
   input logic        reset,
   input logic        out_valid_i,
   input logic        out_ready_i,
   input logic [31:0] out_data_i,
   input logic        out_sop_i,
   input logic        out_eop_i
);

   int   assert_fails;
   logic in_pkt;
   logic xfer;

   initial assert_fails = 0;

   assign xfer = out_valid_i && out_ready_i;

   // set between a start-of-packet transfer and the matching end-of-packet transfer.
   always_ff @(posedge clk)
   begin
      if (reset)
         in_pkt <= 1'b0;
      else if (xfer && out_eop_i)
         in_pkt <= 1'b0;
      else if (xfer && out_sop_i)
         in_pkt <= 1'b1;
   end

   stall_hold: assert property (@(posedge clk) disable iff (reset)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i)
                                      && $stable(out_sop_i) && $stable(out_eop_i))
   else
   begin
      assert_fails++;
      $error("output word changed or was withdrawn while stalled");
   end

   sop_outside: assert property (@(posedge clk) disable iff (reset)
      xfer && out_sop_i |-> !in_pkt)
   else
   begin
      assert_fails++;
      $error("start of packet inside an open packet");
   end

   word_inside: assert property (@(posedge clk) disable iff (reset)
      xfer && !out_sop_i |-> in_pkt)
   else
   begin
      assert_fails++;
      $error("packet word outside of a packet");
   end

   idle_after_reset: assert property (@(posedge clk) reset |=> !out_valid_i)
   else
   begin
      assert_fails++;
      $error("output valid high after reset");
   end

endmodule

bind ctx_report_top ctx_report_checker u_checker
(
   .clk         (clk),
   .reset       (reset),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .out_data_i  (out_data_o),
   .out_sop_i   (out_sop_o),
   .out_eop_i   (out_eop_o)
);

`default_nettype wire

// File: ctx_report_top.sv
`default_nettype none

module ctx_report_top
#(
   parameter bit PROT_ENG_FLAGS  = 1'b1,
   parameter int FIFO_DEPTH_LOG2 = ctx_pkg::CTX_FIFO_DEPTH_LOG2
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   evt_valid_i,
   input  ctx_pkg::ctx_evt_code_t evt_code_i,
   input  logic [63:0]            vita_time_i,
   input  logic [31:0]            seqnum0_i,
   input  logic [31:0]            seqnum1_i,
   input  logic [31:0]            stream_id_i,
   output logic                   evt_ready_o,
   output logic                   out_valid_o,
   output logic [31:0]            out_data_o,
   output logic                   out_sop_o,
   output logic                   out_eop_o,
   input  logic                   out_ready_i
);

   logic               dec_valid;
   logic               dec_ready;
   ctx_pkg::ctx_req_t  dec_data;
   logic               req_valid;
   logic               req_ready;
   ctx_pkg::ctx_req_t  req_data;
   ctx_pkg::ctx_word_t word_in;
   ctx_pkg::ctx_word_t word_out;

   ctx_word_if word_bus ();

   ctx_event_decode u_decode
   (
      .clk         (clk),
      .reset       (reset),
      .evt_valid_i (evt_valid_i),
      .evt_code_i  (evt_code_i),
      .vita_time_i (vita_time_i),
      .seqnum0_i   (seqnum0_i),
      .seqnum1_i   (seqnum1_i),
      .req_ready_i (dec_ready),
      .evt_ready_o (evt_ready_o),
      .req_valid_o (dec_valid),
      .req_data_o  (dec_data)
   );

   ctx_short_fifo #(.T(ctx_pkg::ctx_req_t), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_req_fifo
   (
      .clk         (clk),
      .reset       (reset),
      .in_valid_i  (dec_valid),
      .in_data_i   (dec_data),
      .in_ready_o  (dec_ready),
      .out_valid_o (req_valid),
      .out_data_o  (req_data),
      .out_ready_i (req_ready)
   );

   ctx_pkt_builder #(.PROT_ENG_FLAGS(PROT_ENG_FLAGS)) u_builder
   (
      .clk         (clk),
      .reset       (reset),
      .req_valid_i (req_valid),
      .req_data_i  (req_data),
      .stream_id_i (stream_id_i),
      .req_ready_o (req_ready),
      .word        (word_bus.producer)
   );

   assign word_in = '{eop: word_bus.eop, sop: word_bus.sop, data: word_bus.data};

   ctx_short_fifo #(.T(ctx_pkg::ctx_word_t), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_word_fifo
   (
      .clk         (clk),
      .reset       (reset),
      .in_valid_i  (word_bus.valid),
      .in_data_i   (word_in),
      .in_ready_o  (word_bus.ready),
      .out_valid_o (out_valid_o),
      .out_data_o  (word_out),
      .out_ready_i (out_ready_i)
   );

   assign out_data_o = word_out.data;
   assign out_sop_o  = word_out.sop;
   assign out_eop_o  = word_out.eop;

endmodule

`default_nettype wire

// File: ctx_pkt_builder.sv
`default_nettype none

module ctx_pkt_builder
#(
   parameter bit PROT_ENG_FLAGS = 1'b1
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              req_valid_i,
   input  ctx_pkg::ctx_req_t req_data_i,
   input  logic [31:0]       stream_id_i,
   output logic              req_ready_o,
   ctx_word_if.producer      word
);

   typedef enum logic [3:0]
   {
      ST_IDLE     = 4'd0,
      ST_PROT_ENG = 4'd1,
      ST_HEADER   = 4'd2,
      ST_STREAMID = 4'd3,
      ST_SECS     = 4'd4,
      ST_TICS     = 4'd5,
      ST_TICS2    = 4'd6,
      ST_MESSAGE  = 4'd7,
      ST_FLOWCTL0 = 4'd8,
      ST_FLOWCTL1 = 4'd9,
      ST_DONE     = 4'd10
   } state_t;

   state_t            state;
   logic [3:0]        seqno;
   ctx_pkg::ctx_req_t req_q;
   logic              type_bit;

   // the header type bit marks a packet sent without the preamble.
   assign type_bit    = !PROT_ENG_FLAGS;
   assign req_ready_o = (state == ST_IDLE);
   assign word.valid  = (state != ST_IDLE) && (state != ST_DONE);

   // ##############################
   // state sequencing
   // ##############################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= ST_IDLE;
         seqno <= 4'd0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (req_valid_i)
               begin
                  state <= PROT_ENG_FLAGS ? ST_PROT_ENG : ST_HEADER;
               end
            end
            ST_DONE:
            begin
               state <= ST_IDLE;
               seqno <= seqno + 4'd1;
            end
            default:
            begin
               if (word.ready)
               begin
                  state <= state_t'(state + 4'd1);
               end
            end
         endcase
      end
   end

   // request fields are held for the whole packet.
   always_ff @(posedge clk)
   begin
      if (state == ST_IDLE && req_valid_i)
      begin
         req_q <= req_data_i;
      end
   end

   // ##############################
   // word formation
   // ##############################

   always_comb
   begin
      word.sop  = 1'b0;
      word.eop  = 1'b0;
      word.data = 32'd0;
      case (state)
         ST_PROT_ENG:
         begin
            word.sop  = 1'b1;
            word.data = ctx_pkg::CTX_PROT_WORD;
         end
         ST_HEADER:
         begin
            word.sop  = type_bit;
            word.data = {type_bit, ctx_pkg::CTX_PKT_TYPE[10:0], seqno, ctx_pkg::CTX_HDR_LEN};
         end
         ST_STREAMID:
         begin
            word.data = stream_id_i;
         end
         ST_SECS:
         begin
            word.data = req_q.vita_time[63:32];
         end
         ST_TICS2:
         begin
            word.data = req_q.vita_time[31:0];
         end
         ST_MESSAGE:
         begin
            word.data = {req_q.msg, req_q.count};
         end
         ST_FLOWCTL0:
         begin
            word.data = req_q.seqnum0;
         end
         ST_FLOWCTL1:
         begin
            word.eop  = 1'b1;
            word.data = req_q.seqnum1;
         end
         default:
         begin
            // TICS carries no fractional time.
            word.data = 32'd0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: ctx_short_fifo.sv
`default_nettype none

module ctx_short_fifo
#(
   parameter type T               = logic [31:0],
   parameter int  FIFO_DEPTH_LOG2 = 4
)
(
   input  logic clk,
   input  logic reset,
   input  logic in_valid_i,
   input  T     in_data_i,
   output logic in_ready_o,
   output logic out_valid_o,
   output T     out_data_o,
   input  logic out_ready_i
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   T                         mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]   count;
   logic                       do_wr;
   logic                       do_rd;

   assign in_ready_o  = (count != DEPTH[FIFO_DEPTH_LOG2:0]);
   assign out_valid_o = (count != '0);
   assign out_data_o  = mem[rd_ptr];

   assign do_wr = in_valid_i && in_ready_o;
   assign do_rd = out_valid_o && out_ready_i;

   always_ff @(posedge clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= in_data_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous read and write leaves the occupancy unchanged.
         if (do_wr && !do_rd)
         begin
            count <= count + 1'b1;
         end
         else if (do_rd && !do_wr)
         begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: ctx_event_decode.sv
`default_nettype none

module ctx_event_decode
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  evt_valid_i,
   input  ctx_pkg::ctx_evt_code_t evt_code_i,
   input  logic [63:0]           vita_time_i,
   input  logic [31:0]           seqnum0_i,
   input  logic [31:0]           seqnum1_i,
   input  logic                  req_ready_i,
   output logic                  evt_ready_o,
   output logic                  req_valid_o,
   output ctx_pkg::ctx_req_t     req_data_o
);

   ctx_pkg::ctx_msg_t msg_cls;
   logic [2:0]        cls_idx;
   logic              is_none;
   logic              accept;
   logic [23:0]       next_cnt;
   logic [23:0]       class_cnt [ctx_pkg::CTX_NUM_CLASSES];

   // ##############################
   // classification
   // ##############################

   always_comb
   begin
      is_none = 1'b0;
      msg_cls = ctx_pkg::MSG_UNKNOWN;
      cls_idx = 3'd6;
      case (evt_code_i)
         ctx_pkg::EVT_NONE:
         begin
            is_none = 1'b1;
         end
         ctx_pkg::EVT_OVERFLOW:
         begin
            msg_cls = ctx_pkg::MSG_OVERFLOW;
            cls_idx = 3'd0;
         end
         ctx_pkg::EVT_UNDERFLOW:
         begin
            msg_cls = ctx_pkg::MSG_UNDERFLOW;
            cls_idx = 3'd1;
         end
         ctx_pkg::EVT_LATE_CMD:
         begin
            msg_cls = ctx_pkg::MSG_LATE_CMD;
            cls_idx = 3'd2;
         end
         ctx_pkg::EVT_SEQ_ERR:
         begin
            msg_cls = ctx_pkg::MSG_SEQ_ERR;
            cls_idx = 3'd3;
         end
         ctx_pkg::EVT_BROKEN_CHAIN:
         begin
            msg_cls = ctx_pkg::MSG_BROKEN_CHAIN;
            cls_idx = 3'd4;
         end
         ctx_pkg::EVT_ACK:
         begin
            msg_cls = ctx_pkg::MSG_ACK;
            cls_idx = 3'd5;
         end
         default:
         begin
            msg_cls = ctx_pkg::MSG_UNKNOWN;
            cls_idx = 3'd6;
         end
      endcase
   end

   // the output slot takes a new event when empty or draining this cycle.
   assign evt_ready_o = !req_valid_o || req_ready_i;
   assign accept      = evt_valid_i && evt_ready_o;
   assign next_cnt    = class_cnt[cls_idx] + 24'd1;

   // ##############################
   // counters and output slot
   // ##############################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_valid_o <= 1'b0;
         for (int i = 0; i < ctx_pkg::CTX_NUM_CLASSES; i++)
         begin
            class_cnt[i] <= 24'd0;
         end
      end
      else
      begin
         if (req_valid_o && req_ready_i)
         begin
            req_valid_o <= 1'b0;
         end
         if (accept && !is_none)
         begin
            req_valid_o        <= 1'b1;
            class_cnt[cls_idx] <= next_cnt;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept && !is_none)
      begin
         req_data_o.msg       <= msg_cls;
         req_data_o.count     <= next_cnt;
         req_data_o.vita_time <= vita_time_i;
         req_data_o.seqnum0   <= seqnum0_i;
         req_data_o.seqnum1   <= seqnum1_i;
      end
   end

endmodule

`default_nettype wire

// File: ctx_word_if.sv
`default_nettype none

// packet word stream between the builder and the word FIFO.
interface ctx_word_if;

   logic        valid;
   logic        ready;
   logic [31:0] data;
   logic        sop;
   logic        eop;

   modport producer
   (
      output valid,
      output data,
      output sop,
      output eop,
      input  ready
   );

   modport consumer
   (
      input  valid,
      input  data,
      input  sop,
      input  eop,
      output ready
   );

endinterface

`default_nettype wire

// File: ctx_pkg.sv
`default_nettype none

package ctx_pkg;

   // incoming event codes. Every value not listed here is an unknown event.
   typedef logic [3:0] ctx_evt_code_t;

   localparam ctx_evt_code_t EVT_NONE         = 4'd0;
   localparam ctx_evt_code_t EVT_OVERFLOW     = 4'd1;
   localparam ctx_evt_code_t EVT_UNDERFLOW    = 4'd2;
   localparam ctx_evt_code_t EVT_LATE_CMD     = 4'd3;
   localparam ctx_evt_code_t EVT_SEQ_ERR      = 4'd4;
   localparam ctx_evt_code_t EVT_BROKEN_CHAIN = 4'd5;
   localparam ctx_evt_code_t EVT_ACK          = 4'd6;

   // message class, sent in the top byte of the MESSAGE word.
   typedef logic [7:0] ctx_msg_t;

   localparam ctx_msg_t MSG_OVERFLOW     = 8'h01;
   localparam ctx_msg_t MSG_UNDERFLOW    = 8'h02;
   localparam ctx_msg_t MSG_LATE_CMD     = 8'h03;
   localparam ctx_msg_t MSG_SEQ_ERR      = 8'h04;
   localparam ctx_msg_t MSG_BROKEN_CHAIN = 8'h05;
   localparam ctx_msg_t MSG_ACK          = 8'h06;
   localparam ctx_msg_t MSG_UNKNOWN      = 8'h0f;

   // six known classes plus the unknown class, each with its own counter.
   localparam int CTX_NUM_CLASSES = 7;

   typedef struct packed {
      ctx_msg_t    msg;
      logic [23:0] count;
      logic [63:0] vita_time;
      logic [31:0] seqnum0;
      logic [31:0] seqnum1;
   } ctx_req_t;

   typedef struct packed {
      logic        eop;
      logic        sop;
      logic [31:0] data;
   } ctx_word_t;

   // the top bit of the header is replaced by the type bit.
   localparam logic [11:0] CTX_PKT_TYPE  = 12'b0101_0000_1101;
   localparam logic [15:0] CTX_HDR_LEN   = 16'd8;
   localparam logic [31:0] CTX_PROT_WORD = {16'd1, 16'd32};

   localparam int CTX_FIFO_DEPTH_LOG2 = 4;

endpackage

`default_nettype wire
